/* hdl/rv_sys_pkg.sv */
// RV64 system unit definitions
package rv_sys_pkg;

  // ***********************************************************
  // widths
  // ***********************************************************
  localparam int XLEN       = 64;
  localparam int INSTR_W    = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int NUM_CSR    = 4;
  localparam int CSR_IDX_W  = 2;

  // ***********************************************************
  // machine CSRs
  // ***********************************************************
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  // storage slot of each CSR, in the same order as the address table.
  localparam logic [CSR_IDX_W-1:0] IDX_MSTATUS = 2'd0;
  localparam logic [CSR_IDX_W-1:0] IDX_MTVEC   = 2'd1;
  localparam logic [CSR_IDX_W-1:0] IDX_MEPC    = 2'd2;
  localparam logic [CSR_IDX_W-1:0] IDX_MCAUSE  = 2'd3;

  localparam logic [CSR_ADDR_W-1:0] CSR_KEYS [NUM_CSR] =
    '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
  localparam logic [CSR_IDX_W-1:0] CSR_IDXS [NUM_CSR] =
    '{IDX_MSTATUS, IDX_MTVEC, IDX_MEPC, IDX_MCAUSE};

  localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_000a_0000_1800; // mpp = m, xl = 64.
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

  // ***********************************************************
  // instruction encodings
  // ***********************************************************
  localparam logic [6:0] OPC_SYSTEM = 7'h73;
  localparam logic [2:0] F3_PRIV    = 3'b000;
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;

  localparam logic [INSTR_W-1:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [INSTR_W-1:0] INSTR_MRET  = 32'h3020_0073;

  typedef enum logic [2:0] {
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_ECALL,
    SYS_MRET,
    SYS_ILLEGAL
  } sys_op_t;

endpackage

/* hdl/rv_key_mux.sv */
// Keyed table lookup
module rv_key_mux #(
  parameter type T     = logic,
  parameter int  N_KEY = 2
) (
  input  logic [rv_sys_pkg::CSR_ADDR_W-1:0] i_key,
  input  logic [rv_sys_pkg::CSR_ADDR_W-1:0] i_keys [N_KEY],
  input  T                                  i_values [N_KEY],
  output T                                  o_value,
  output logic                              o_hit
);

  // keys are expected to be unique, so at most one entry matches.
  always_comb begin
    o_value = '0;
    o_hit   = 1'b0;
    for (int k = 0; k < N_KEY; k++) begin
      if (i_key == i_keys[k]) begin
        o_value = i_values[k];
        o_hit   = 1'b1;
      end
    end
  end

endmodule

/* hdl/rv_sys_decode.sv */
// System instruction decoder
module rv_sys_decode (
  input  logic [rv_sys_pkg::INSTR_W-1:0]    i_instr,
  output rv_sys_pkg::sys_op_t               o_op,
  output logic [rv_sys_pkg::CSR_ADDR_W-1:0] o_csr_addr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_system;
  logic       is_ecall;
  logic       is_mret;

  // ***********************************************************
  // field extraction
  // ***********************************************************
  assign opcode     = i_instr[6:0];
  assign funct3     = i_instr[14:12];
  assign o_csr_addr = i_instr[31:20]; // csr field of the I-type layout.

  assign is_system = (opcode == rv_sys_pkg::OPC_SYSTEM);

  // privileged ops have no free fields, so the whole word must match.
  assign is_ecall = (i_instr == rv_sys_pkg::INSTR_ECALL);
  assign is_mret  = (i_instr == rv_sys_pkg::INSTR_MRET);

  // ***********************************************************
  // classification
  // ***********************************************************
  always_comb begin
    o_op = rv_sys_pkg::SYS_ILLEGAL;
    if (is_system) begin
      case (funct3)
        rv_sys_pkg::F3_CSRRW: o_op = rv_sys_pkg::SYS_CSRRW;
        rv_sys_pkg::F3_CSRRS: o_op = rv_sys_pkg::SYS_CSRRS;
        rv_sys_pkg::F3_PRIV: begin
          if (is_ecall) begin
            o_op = rv_sys_pkg::SYS_ECALL;
          end else if (is_mret) begin
            o_op = rv_sys_pkg::SYS_MRET;
          end
        end
        default: o_op = rv_sys_pkg::SYS_ILLEGAL; // csrrc and immediate forms land here.
      endcase
    end
  end

endmodule

/* hdl/rv_csr_file.sv */
// Machine CSR file
module rv_csr_file (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_commit,
  input  rv_sys_pkg::sys_op_t               i_op,
  input  logic [rv_sys_pkg::CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [rv_sys_pkg::XLEN-1:0]       i_wdata,
  input  logic [rv_sys_pkg::XLEN-1:0]       i_pc,
  output logic [rv_sys_pkg::XLEN-1:0]       o_rdata,
  output logic                              o_redirect,
  output logic [rv_sys_pkg::XLEN-1:0]       o_next_pc
);

  logic [rv_sys_pkg::XLEN-1:0]       csr_q    [rv_sys_pkg::NUM_CSR];
  logic [rv_sys_pkg::CSR_ADDR_W-1:0] csr_keys [rv_sys_pkg::NUM_CSR];
  logic [rv_sys_pkg::CSR_IDX_W-1:0]  csr_idxs [rv_sys_pkg::NUM_CSR];

  logic [rv_sys_pkg::XLEN-1:0]      rd_value;
  logic                             rd_hit;
  logic [rv_sys_pkg::CSR_IDX_W-1:0] wr_idx;
  logic                             wr_hit;
  logic                             is_csr_op;

  assign csr_keys = rv_sys_pkg::CSR_KEYS;
  assign csr_idxs = rv_sys_pkg::CSR_IDXS;

  // ***********************************************************
  // address lookup
  // ***********************************************************
  rv_key_mux #(
    .T     (logic [rv_sys_pkg::XLEN-1:0]),
    .N_KEY (rv_sys_pkg::NUM_CSR)
  ) u_rd_mux (
    .i_key    (i_csr_addr),
    .i_keys   (csr_keys),
    .i_values (csr_q),
    .o_value  (rd_value),
    .o_hit    (rd_hit)
  );

  rv_key_mux #(
    .T     (logic [rv_sys_pkg::CSR_IDX_W-1:0]),
    .N_KEY (rv_sys_pkg::NUM_CSR)
  ) u_idx_mux (
    .i_key    (i_csr_addr),
    .i_keys   (csr_keys),
    .i_values (csr_idxs),
    .o_value  (wr_idx),
    .o_hit    (wr_hit)
  );

  assign is_csr_op = (i_op == rv_sys_pkg::SYS_CSRRW) || (i_op == rv_sys_pkg::SYS_CSRRS);
  assign o_rdata   = (is_csr_op && rd_hit) ? rd_value : '0; // old value, before the commit edge.

  // ***********************************************************
  // redirect target
  // ***********************************************************
  always_comb begin
    o_redirect = 1'b0;
    o_next_pc  = '0;
    case (i_op)
      rv_sys_pkg::SYS_ECALL: begin
        o_redirect = 1'b1;
        o_next_pc  = csr_q[rv_sys_pkg::IDX_MTVEC];
      end
      rv_sys_pkg::SYS_MRET: begin
        o_redirect = 1'b1;
        o_next_pc  = csr_q[rv_sys_pkg::IDX_MEPC];
      end
      default: ;
    endcase
  end

  // ***********************************************************
  // state update
  // ***********************************************************
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      csr_q[rv_sys_pkg::IDX_MSTATUS] <= rv_sys_pkg::MSTATUS_RESET;
      csr_q[rv_sys_pkg::IDX_MTVEC]   <= '0;
      csr_q[rv_sys_pkg::IDX_MEPC]    <= '0;
      csr_q[rv_sys_pkg::IDX_MCAUSE]  <= '0;
    end else if (i_commit) begin
      case (i_op)
        rv_sys_pkg::SYS_CSRRW: begin
          if (wr_hit) csr_q[wr_idx] <= i_wdata; // unmapped writes are dropped.
        end
        rv_sys_pkg::SYS_CSRRS: begin
          if (wr_hit) csr_q[wr_idx] <= csr_q[wr_idx] | i_wdata;
        end
        rv_sys_pkg::SYS_ECALL: begin
          csr_q[rv_sys_pkg::IDX_MEPC]   <= i_pc;
          csr_q[rv_sys_pkg::IDX_MCAUSE] <= rv_sys_pkg::CAUSE_ECALL_M;
        end
        default: ; // mret and illegal leave the state alone.
      endcase
    end
  end

endmodule

/* hdl/rv_sys_ctrl.sv */
// Request and acknowledge sequencer
module rv_sys_ctrl (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_req,
  input  logic                        i_illegal,
  input  logic [rv_sys_pkg::XLEN-1:0] i_rdata,
  input  logic [rv_sys_pkg::XLEN-1:0] i_next_pc,
  input  logic                        i_redirect,
  output logic                        o_commit,
  output logic                        o_ack,
  output logic [rv_sys_pkg::XLEN-1:0] o_rdata,
  output logic [rv_sys_pkg::XLEN-1:0] o_next_pc,
  output logic                        o_redirect,
  output logic                        o_illegal
);

  typedef enum logic {
    ST_IDLE,
    ST_ACKED
  } state_t;

  state_t state_q;

  // only the idle state can commit, so a held request is applied once.
  assign o_commit = (state_q == ST_IDLE) && i_req;
  assign o_ack    = (state_q == ST_ACKED);

  // ***********************************************************
  // handshake FSM
  // ***********************************************************
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (i_req) state_q <= ST_ACKED;
        ST_ACKED: if (!i_req) state_q <= ST_IDLE; // wait for the requester to let go.
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // results are captured on the same edge that updates the CSRs.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdata    <= '0;
      o_next_pc  <= '0;
      o_redirect <= 1'b0;
      o_illegal  <= 1'b0;
    end else if (o_commit) begin
      o_rdata    <= i_rdata;
      o_next_pc  <= i_next_pc;
      o_redirect <= i_redirect;
      o_illegal  <= i_illegal;
    end
  end

endmodule

/* hdl/rv_sys_unit.sv */
// Machine-mode system unit
module rv_sys_unit (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_req,
  input  logic [rv_sys_pkg::INSTR_W-1:0] i_instr,
  input  logic [rv_sys_pkg::XLEN-1:0]    i_pc,
  input  logic [rv_sys_pkg::XLEN-1:0]    i_wdata,
  output logic                           o_ack,
  output logic [rv_sys_pkg::XLEN-1:0]    o_rdata,
  output logic                           o_redirect,
  output logic [rv_sys_pkg::XLEN-1:0]    o_next_pc,
  output logic                           o_illegal
);

  rv_sys_pkg::sys_op_t               op;
  logic [rv_sys_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic                              illegal;
  logic                              commit;
  logic [rv_sys_pkg::XLEN-1:0]       csr_rdata;
  logic                              csr_redirect;
  logic [rv_sys_pkg::XLEN-1:0]       csr_next_pc;

  // ***********************************************************
  // decode
  // ***********************************************************
  rv_sys_decode u_decode (
    .i_instr    (i_instr),
    .o_op       (op),
    .o_csr_addr (csr_addr)
  );

  assign illegal = (op == rv_sys_pkg::SYS_ILLEGAL);

  // ***********************************************************
  // handshake and result registers
  // ***********************************************************
  rv_sys_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (i_req),
    .i_illegal  (illegal),
    .i_rdata    (csr_rdata),
    .i_next_pc  (csr_next_pc),
    .i_redirect (csr_redirect),
    .o_commit   (commit),
    .o_ack      (o_ack),
    .o_rdata    (o_rdata),
    .o_next_pc  (o_next_pc),
    .o_redirect (o_redirect),
    .o_illegal  (o_illegal)
  );

  // ***********************************************************
  // CSR state
  // ***********************************************************
  rv_csr_file u_csr_file (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_commit   (commit),
    .i_op       (op),
    .i_csr_addr (csr_addr),
    .i_wdata    (i_wdata),
    .i_pc       (i_pc),
    .o_rdata    (csr_rdata),
    .o_redirect (csr_redirect),
    .o_next_pc  (csr_next_pc)
  );

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset
module tb_clock_gen #(
  parameter int CLK_PERIOD = 4,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // reset is released just after an edge so that no edge sees it change.
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

/* test/rv_sys_unit_properties.sv */
// Handshake and result properties
module rv_sys_unit_properties (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_req,
  input logic i_ack,
  input logic i_redirect,
  input logic i_illegal
);

  int fail_count = 0; // read by the testbench at the end of the run.

  // ***********************************************************
  // handshake
  // ***********************************************************
  ack_rise_on_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_ack) |-> $past(i_req))
  else begin
    $error("o_ack rose without a request at the previous edge");
    fail_count++;
  end

  ack_fall_after_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_ack) |-> !$past(i_req))
  else begin
    $error("o_ack fell while the request was still high");
    fail_count++;
  end

  ack_low_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_ack)
  else begin
    $error("o_ack was high right after reset");
    fail_count++;
  end

  // an illegal instruction never redirects.
  no_redirect_when_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_redirect && i_illegal))
  else begin
    $error("o_redirect and o_illegal were high together");
    fail_count++;
  end

endmodule

bind rv_sys_unit rv_sys_unit_properties u_props (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_req      (i_req),
  .i_ack      (o_ack),
  .i_redirect (o_redirect),
  .i_illegal  (o_illegal)
);

/* test/rv_sys_unit_tb.sv */
// System unit testbench
module rv_sys_unit_tb;

  typedef struct packed {
    logic [rv_sys_pkg::INSTR_W-1:0] instr;
    logic [rv_sys_pkg::XLEN-1:0]    pc;
    logic [rv_sys_pkg::XLEN-1:0]    wdata;
    logic [rv_sys_pkg::XLEN-1:0]    rdata;
    logic                           redirect;
    logic [rv_sys_pkg::XLEN-1:0]    next_pc;
    logic                           illegal;
  } vector_t;

  logic                           clk;
  logic                           rst_n;
  logic                           req;
  logic [rv_sys_pkg::INSTR_W-1:0] instr;
  logic [rv_sys_pkg::XLEN-1:0]    pc;
  logic [rv_sys_pkg::XLEN-1:0]    wdata;
  logic                           ack;
  logic [rv_sys_pkg::XLEN-1:0]    rdata;
  logic                           redirect;
  logic [rv_sys_pkg::XLEN-1:0]    next_pc;
  logic                           illegal;

  vector_t vectors [$];
  int      seed = 29;
  int      entry_errs = 0;
  int      failed_entries = 0;
  int      cycle_count = 0;
  int      cycle_limit = 0;
  int      rst_cycles = 0;

  tb_clock_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rv_sys_unit dut0 (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_req      (req),
    .i_instr    (instr),
    .i_pc       (pc),
    .i_wdata    (wdata),
    .o_ack      (ack),
    .o_rdata    (rdata),
    .o_redirect (redirect),
    .o_next_pc  (next_pc),
    .o_illegal  (illegal)
  );

  // ***********************************************************
  // stimulus table
  // ***********************************************************
  function automatic logic [31:0] build_instr(input logic [11:0] addr, input logic [2:0] f3,
                                              input logic [6:0] opcode);
    return {addr, 5'd1, f3, 5'd2, opcode}; // rs1 = x1, rd = x2.
  endfunction

  function automatic void add_csr_op(input logic [2:0] f3, input logic [11:0] addr,
                                     input logic [63:0] w, input logic [63:0] exp_rdata);
    vector_t v;
    v = '0;
    v.instr = build_instr(addr, f3, rv_sys_pkg::OPC_SYSTEM);
    v.pc    = 64'h100;
    v.wdata = w;
    v.rdata = exp_rdata;
    vectors.push_back(v);
  endfunction

  function automatic void add_redirect(input logic [31:0] ins, input logic [63:0] p,
                                       input logic [63:0] target);
    vector_t v;
    v = '0;
    v.instr    = ins;
    v.pc       = p;
    v.redirect = 1'b1;
    v.next_pc  = target;
    vectors.push_back(v);
  endfunction

  function automatic void add_illegal(input logic [31:0] ins, input logic [63:0] w);
    vector_t v;
    v = '0;
    v.instr   = ins;
    v.pc      = 64'h3000;
    v.wdata   = w;
    v.illegal = 1'b1;
    vectors.push_back(v);
  endfunction

  function automatic void fill_table();
    // reset values, then read-old-value on mtvec.
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MSTATUS, 64'h0, 64'h0000_000a_0000_1800);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MTVEC, 64'h0, 64'h0);
    add_csr_op(rv_sys_pkg::F3_CSRRW, rv_sys_pkg::CSR_MTVEC, 64'h8000_0100, 64'h0);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MTVEC, 64'h4, 64'h8000_0100);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MTVEC, 64'h0, 64'h8000_0104);
    // trap entry and return.
    add_redirect(rv_sys_pkg::INSTR_ECALL, 64'h1000, 64'h8000_0104);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MEPC, 64'h0, 64'h1000);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MCAUSE, 64'h0, 64'd11);
    add_redirect(rv_sys_pkg::INSTR_MRET, 64'h1004, 64'h1000);
    add_csr_op(rv_sys_pkg::F3_CSRRW, rv_sys_pkg::CSR_MEPC, 64'h2000, 64'h1000);
    add_redirect(rv_sys_pkg::INSTR_MRET, 64'h1008, 64'h2000);
    // unmapped address, then re-read all four CSRs.
    add_csr_op(rv_sys_pkg::F3_CSRRW, 12'h7c0, '1, 64'h0);
    add_csr_op(rv_sys_pkg::F3_CSRRS, 12'h7c0, 64'h0, 64'h0);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MSTATUS, 64'h0, 64'h0000_000a_0000_1800);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MTVEC, 64'h0, 64'h8000_0104);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MEPC, 64'h0, 64'h2000);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MCAUSE, 64'h0, 64'd11);
    // illegal encodings must not touch any state.
    add_illegal(build_instr(rv_sys_pkg::CSR_MTVEC, rv_sys_pkg::F3_CSRRW, 7'h13), 64'hdead);
    add_illegal(build_instr(rv_sys_pkg::CSR_MTVEC, 3'b011, rv_sys_pkg::OPC_SYSTEM), 64'hffff);
    add_illegal(rv_sys_pkg::INSTR_ECALL | 32'h0000_0080, 64'h0);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MTVEC, 64'h0, 64'h8000_0104);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MEPC, 64'h0, 64'h2000);
    // a second commit during a long hold would change rdata.
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MCAUSE, 64'h100, 64'd11);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MCAUSE, 64'h200, 64'h10b);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MCAUSE, 64'h0, 64'h30b);
    add_csr_op(rv_sys_pkg::F3_CSRRW, rv_sys_pkg::CSR_MTVEC, 64'h40, 64'h8000_0104);
    add_redirect(rv_sys_pkg::INSTR_ECALL, 64'h4000, 64'h40);
    add_csr_op(rv_sys_pkg::F3_CSRRS, rv_sys_pkg::CSR_MEPC, 64'h0, 64'h4000);
  endfunction

  // ***********************************************************
  // driving and checking
  // ***********************************************************
  task automatic wait_edge();
    @(posedge clk);
    #1; // drive and sample away from the edge.
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      entry_errs++;
    end
  endtask

  task automatic check_results(input vector_t v, input string phase);
    check_value({phase, " rdata"}, rdata, v.rdata);
    check_value({phase, " next_pc"}, next_pc, v.next_pc);
    check_value({phase, " redirect"}, 64'(redirect), 64'(v.redirect));
    check_value({phase, " illegal"}, 64'(illegal), 64'(v.illegal));
  endtask

  task automatic apply_entry(input int idx);
    int      hold;
    vector_t v;
    v          = vectors[idx];
    entry_errs = 0;
    instr      = v.instr;
    pc         = v.pc;
    wdata      = v.wdata;
    req        = 1'b1;
    do wait_edge(); while (ack !== 1'b1);
    check_results(v, "on ack");
    hold = $random(seed) & 3;
    repeat (hold) wait_edge();
    check_results(v, "after hold"); // results must survive the held request.
    req = 1'b0;
    do wait_edge(); while (ack !== 1'b0);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (!rst_n) rst_cycles++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: the handshake did not complete within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    req   = 1'b0;
    instr = '0;
    pc    = '0;
    wdata = '0;
    fill_table();
    wait (rst_n === 1'b1);
    wait_edge();
    cycle_limit = vectors.size() * 8 + rst_cycles;
    for (int k = 0; k < vectors.size(); k++) begin
      apply_entry(k);
      if (entry_errs == 0) begin
        $display("entry %0d instr 0x%08h: ok", k, vectors[k].instr);
      end else begin
        $display("entry %0d instr 0x%08h: %0d wrong values", k, vectors[k].instr, entry_errs);
        failed_entries++;
      end
    end
    $display("entries run: %0d, entries failed: %0d, property failures: %0d",
             vectors.size(), failed_entries, dut0.u_props.fail_count);
    if (failed_entries == 0 && dut0.u_props.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/rv_sys_pkg.sv
hdl/rv_key_mux.sv
hdl/rv_sys_decode.sv
hdl/rv_csr_file.sv
hdl/rv_sys_ctrl.sv
hdl/rv_sys_unit.sv
test/tb_clock_gen.sv
test/rv_sys_unit_properties.sv
test/rv_sys_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rv_sys_unit_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   ?= Finished with errors
PASS_MSG   ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
